//--- logic/pex_macros.svh
`ifndef PEX_MACROS_SVH
`define PEX_MACROS_SVH

// datapath widths
`define PEX_DATA_W          64
`define PEX_LANES           4
`define PEX_PROTO_W         8
`define PEX_CLASS_W         2
`define PEX_MODE_W          2

// segment modes, code 3 reserved
`define PEX_MODE_SEG1       2'd0
`define PEX_MODE_SEG2       2'd1
`define PEX_MODE_SEG4       2'd2

// ip protocol numbers
`define PEX_PROTO_ICMP      8'h01
`define PEX_PROTO_TCP       8'h06
`define PEX_PROTO_UDP       8'h11

// per-lane class codes
`define PEX_CLASS_OTHER     2'd0
`define PEX_CLASS_ICMP      2'd1
`define PEX_CLASS_TCP       2'd2
`define PEX_CLASS_UDP       2'd3

// extraction + compare stages
// data side is delayed by the same amount
`define PEX_CLASSIFY_LAT    2

`endif

//--- logic/pex_pkg.sv
`include "pex_macros.svh"

package pex_pkg;

    // one full data word
    typedef logic [`PEX_DATA_W-1:0] data_t;

    // segment mode, see PEX_MODE_* codes
    typedef logic [`PEX_MODE_W-1:0] mode_t;

    // protocol byte, upper 8 bits of a segment
    typedef logic [`PEX_PROTO_W-1:0] proto_t;

    // class code of one lane
    typedef logic [`PEX_CLASS_W-1:0] class_t;

    // class codes of all lanes
    // lane 0 sits in the low bits
    typedef logic [`PEX_LANES*`PEX_CLASS_W-1:0] class_vec_t;

endpackage

//--- logic/proto_classify.sv
`timescale 1ns/1ps
`include "pex_macros.svh"

module proto_classify (
    input  logic                clk,
    input  logic                rst_i,
    input  logic                dval_i,
    input  pex_pkg::data_t      data_i,
    input  pex_pkg::mode_t      mode_i,
    output logic                cls_valid_o,
    output pex_pkg::class_vec_t cls_vec_o
);

    // byte picked for each lane, combinational
    pex_pkg::proto_t lane_byte_d [`PEX_LANES];
    // stage 1 registers
    pex_pkg::proto_t lane_byte_q [`PEX_LANES];
    logic            st1_valid_q;
    // stage 2 registers
    pex_pkg::class_vec_t cls_vec_q;
    logic                cls_valid_q;

    // protocol byte to class code
    function automatic pex_pkg::class_t classify_byte(input pex_pkg::proto_t b);
        case (b)
            `PEX_PROTO_ICMP: return `PEX_CLASS_ICMP;
            `PEX_PROTO_TCP:  return `PEX_CLASS_TCP;
            `PEX_PROTO_UDP:  return `PEX_CLASS_UDP;
            default:         return `PEX_CLASS_OTHER;
        endcase
    endfunction

    // lane extraction
    // unused lanes get zero, which classifies as other
    always_comb begin
        for (int k = 0; k < `PEX_LANES; k++) begin
            lane_byte_d[k] = '0;
        end
        case (mode_i)
            `PEX_MODE_SEG1: begin
                // whole word is one segment
                lane_byte_d[0] = data_i[63:56];
            end
            `PEX_MODE_SEG2: begin
                // two 32-bit halves
                lane_byte_d[0] = data_i[31:24];
                lane_byte_d[1] = data_i[63:56];
            end
            `PEX_MODE_SEG4: begin
                // four 16-bit quarters, top byte of each
                for (int k = 0; k < `PEX_LANES; k++) begin
                    lane_byte_d[k] = data_i[16*k+8 +: 8];
                end
            end
            default: begin
                // reserved mode, leave lanes cleared
            end
        endcase
    end

    // stage 1: hold extracted bytes
    always_ff @(posedge clk) begin
        if (dval_i) begin
            for (int k = 0; k < `PEX_LANES; k++) begin
                lane_byte_q[k] <= lane_byte_d[k];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            st1_valid_q <= 1'b0;
            cls_valid_q <= 1'b0;
        end else begin
            st1_valid_q <= dval_i;
            cls_valid_q <= st1_valid_q;
        end
    end

    // stage 2: compare against the three protocol codes
    always_ff @(posedge clk) begin
        if (st1_valid_q) begin
            for (int k = 0; k < `PEX_LANES; k++) begin
                cls_vec_q[k*`PEX_CLASS_W +: `PEX_CLASS_W] <= classify_byte(lane_byte_q[k]);
            end
        end
    end

    assign cls_valid_o = cls_valid_q;
    assign cls_vec_o   = cls_vec_q;

    // reserved mode code must never come with data
    a_mode_legal: assert property (
        @(posedge clk) disable iff (rst_i)
        dval_i |-> (mode_i inside {`PEX_MODE_SEG1, `PEX_MODE_SEG2, `PEX_MODE_SEG4})
    ) else $error("proto_classify: reserved mode %0d with dval_i", mode_i);

endmodule

//--- logic/data_align_delay.sv
`timescale 1ns/1ps
`include "pex_macros.svh"

module data_align_delay #(
    parameter int DEPTH = `PEX_CLASSIFY_LAT
) (
    input  logic           clk,
    input  logic           rst_i,
    input  logic           dval_i,
    input  pex_pkg::data_t data_i,
    input  pex_pkg::mode_t mode_i,
    output logic           dly_valid_o,
    output pex_pkg::data_t dly_data_o,
    output pex_pkg::mode_t dly_mode_o
);

    // one slot per pipeline stage of the classifier
    pex_pkg::data_t data_q  [DEPTH];
    pex_pkg::mode_t mode_q  [DEPTH];
    logic           valid_q [DEPTH];

    // valid chain, cleared on reset
    always_ff @(posedge clk) begin
        if (rst_i) begin
            for (int i = 0; i < DEPTH; i++) begin
                valid_q[i] <= 1'b0;
            end
        end else begin
            valid_q[0] <= dval_i;
            for (int i = 1; i < DEPTH; i++) begin
                valid_q[i] <= valid_q[i-1];
            end
        end
    end

    // word and mode shift along with it
    // every slot moves each cycle so back-to-back words stay in order
    always_ff @(posedge clk) begin
        data_q[0] <= data_i;
        mode_q[0] <= mode_i;
        for (int i = 1; i < DEPTH; i++) begin
            data_q[i] <= data_q[i-1];
            mode_q[i] <= mode_q[i-1];
        end
    end

    // last slot lines up with cls_valid_o
    assign dly_valid_o = valid_q[DEPTH-1];
    assign dly_data_o  = data_q[DEPTH-1];
    assign dly_mode_o  = mode_q[DEPTH-1];

endmodule

//--- logic/seg_mask_deposit.sv
`timescale 1ns/1ps
`include "pex_macros.svh"

module seg_mask_deposit (
    input  logic                clk,
    input  logic                rst_i,
    input  logic                cls_valid_i,
    input  pex_pkg::class_vec_t cls_vec_i,
    input  logic                dly_valid_i,
    input  pex_pkg::data_t      dly_data_i,
    input  pex_pkg::mode_t      dly_mode_i,
    output logic                dval_o,
    output pex_pkg::data_t      data_o
);

    // per-lane class split out of the vector
    pex_pkg::class_t lane_cls [`PEX_LANES];
    // full-word keep mask
    pex_pkg::data_t  keep_d;
    // output registers
    pex_pkg::data_t  data_q;
    logic            dval_q;

    // keep mask for one segment sitting at bit 0
    // upper part of the segment survives, width set by class
    function automatic pex_pkg::data_t keep_mask(
        input pex_pkg::class_t cls,
        input int              seg_w
    );
        int             keep_w;
        pex_pkg::data_t m;
        case (cls)
            `PEX_CLASS_ICMP: keep_w = seg_w / 2;
            `PEX_CLASS_TCP:  keep_w = seg_w;
            `PEX_CLASS_UDP:  keep_w = (seg_w * 3) / 4;
            default:         keep_w = 0;
        endcase
        m = '0;
        for (int b = 0; b < `PEX_DATA_W; b++) begin
            if (b < seg_w && b >= seg_w - keep_w) begin
                m[b] = 1'b1;
            end
        end
        return m;
    endfunction

    always_comb begin
        for (int k = 0; k < `PEX_LANES; k++) begin
            lane_cls[k] = cls_vec_i[k*`PEX_CLASS_W +: `PEX_CLASS_W];
        end
    end

    // assemble the word mask from the segments of this mode
    always_comb begin
        keep_d = '0;
        case (dly_mode_i)
            `PEX_MODE_SEG1: begin
                keep_d = keep_mask(lane_cls[0], `PEX_DATA_W);
            end
            `PEX_MODE_SEG2: begin
                // lane 1 owns the upper half
                keep_d = keep_mask(lane_cls[0], `PEX_DATA_W / 2)
                       | (keep_mask(lane_cls[1], `PEX_DATA_W / 2) << (`PEX_DATA_W / 2));
            end
            `PEX_MODE_SEG4: begin
                for (int k = 0; k < `PEX_LANES; k++) begin
                    keep_d = keep_d
                           | (keep_mask(lane_cls[k], `PEX_DATA_W / 4) << (k * `PEX_DATA_W / 4));
                end
            end
            default: begin
                // reserved mode clears the word
                keep_d = '0;
            end
        endcase
    end

    // masked word, only loaded for live data
    always_ff @(posedge clk) begin
        if (dly_valid_i) begin
            data_q <= dly_data_i & keep_d;
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            dval_q <= 1'b0;
        end else begin
            dval_q <= dly_valid_i;
        end
    end

    assign dval_o = dval_q;
    assign data_o = data_q;

    // classifier and delay line must stay in lockstep
    a_align: assert property (
        @(posedge clk) disable iff (rst_i)
        cls_valid_i == dly_valid_i
    ) else $error("seg_mask_deposit: class and data valid out of step");

endmodule

//--- logic/pex_top.sv
`timescale 1ns/1ps
`include "pex_macros.svh"

module pex_top (
    input  logic           clk,
    input  logic           rst_i,
    input  logic           dval_i,
    input  pex_pkg::data_t data_i,
    input  pex_pkg::mode_t mode_i,
    output logic           dval_o,
    output pex_pkg::data_t data_o
);

    // classifier results
    logic                cls_valid;
    pex_pkg::class_vec_t cls_vec;

    // word, mode and valid aligned to the classifier
    logic                dly_valid;
    pex_pkg::data_t      dly_data;
    pex_pkg::mode_t      dly_mode;

    // protocol byte extraction and compare
    proto_classify u_classify (
        .clk         (clk),
        .rst_i       (rst_i),
        .dval_i      (dval_i),
        .data_i      (data_i),
        .mode_i      (mode_i),
        .cls_valid_o (cls_valid),
        .cls_vec_o   (cls_vec)
    );

    // carries the word alongside classification
    data_align_delay #(
        .DEPTH (`PEX_CLASSIFY_LAT)
    ) u_delay (
        .clk         (clk),
        .rst_i       (rst_i),
        .dval_i      (dval_i),
        .data_i      (data_i),
        .mode_i      (mode_i),
        .dly_valid_o (dly_valid),
        .dly_data_o  (dly_data),
        .dly_mode_o  (dly_mode)
    );

    // per-segment masking, one more register
    seg_mask_deposit u_deposit (
        .clk         (clk),
        .rst_i       (rst_i),
        .cls_valid_i (cls_valid),
        .cls_vec_i   (cls_vec),
        .dly_valid_i (dly_valid),
        .dly_data_i  (dly_data),
        .dly_mode_i  (dly_mode),
        .dval_o      (dval_o),
        .data_o      (data_o)
    );

endmodule

//--- dv/pex_tb.sv
`timescale 1ns/1ps
`include "pex_macros.svh"

module pex_tb;

    logic                clk = 1'b0;
    logic                rst_i;
    logic                dval_i;
    pex_pkg::data_t      data_i;
    pex_pkg::mode_t      mode_i;
    logic                dval_o;
    pex_pkg::data_t      data_o;

    // scoreboard, front entry is the oldest word in flight
    pex_pkg::data_t      exp_data_q [$];
    int                  exp_cyc_q  [$];
    int                  cyc = 0;
    int                  errors = 0;
    int                  n_in = 0;
    int                  n_out = 0;
    int                  seed_val;
    logic                mon_exp_v;

    pex_top dut0 (
        .clk    (clk),
        .rst_i  (rst_i),
        .dval_i (dval_i),
        .data_i (data_i),
        .mode_i (mode_i),
        .dval_o (dval_o),
        .data_o (data_o)
    );

    // 8 ns clock
    always #4 clk = ~clk;

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    task automatic check_data(input string name, input pex_pkg::data_t exp,
                              input pex_pkg::data_t act);
        if (act !== exp) begin
            $display("ERROR @%0t: %s expected %h actual %h", $time, name, exp, act);
            errors++;
        end
    endtask

    task automatic check_valid(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("ERROR @%0t: %s expected %b actual %b", $time, name, exp, act);
            errors++;
        end
    endtask

    // expected word from the segment rules
    // keep fraction in quarters: icmp 2, tcp 4, udp 3, other 0
    function automatic pex_pkg::data_t model_word(input pex_pkg::data_t d,
                                                  input pex_pkg::mode_t m);
        int              nseg;
        int              seg_w;
        int              quarters;
        int              lo;
        pex_pkg::proto_t p;
        pex_pkg::data_t  res;
        if (m == `PEX_MODE_SEG1) begin
            nseg = 1;
        end else if (m == `PEX_MODE_SEG2) begin
            nseg = 2;
        end else begin
            nseg = 4;
        end
        seg_w = `PEX_DATA_W / nseg;
        res = '0;
        for (int s = 0; s < nseg; s++) begin
            // protocol byte is the top byte of the segment
            p = d[s*seg_w + seg_w - 8 +: 8];
            if (p == `PEX_PROTO_ICMP) quarters = 2;
            else if (p == `PEX_PROTO_TCP) quarters = 4;
            else if (p == `PEX_PROTO_UDP) quarters = 3;
            else quarters = 0;
            lo = s*seg_w + seg_w - (seg_w * quarters) / 4;
            for (int b = lo; b < (s + 1) * seg_w; b++) begin
                res[b] = d[b];
            end
        end
        return res;
    endfunction

    // output monitor, samples on the falling edge where outputs are stable
    // dval_o is due three rising edges after the sampling edge
    always @(negedge clk) begin
        if (cyc >= 1) begin
            mon_exp_v = (exp_cyc_q.size() != 0) && (exp_cyc_q[0] == cyc);
            check_valid("dval_o", mon_exp_v, dval_o);
            if (dval_o === 1'b1) begin
                n_out++;
            end
            if (mon_exp_v) begin
                if (dval_o === 1'b1) begin
                    check_data("data_o", exp_data_q[0], data_o);
                end
                void'(exp_data_q.pop_front());
                void'(exp_cyc_q.pop_front());
            end
        end
    end

    // one word per falling edge, sampled at the next rising edge
    task automatic send_word(input pex_pkg::data_t d, input pex_pkg::mode_t m,
                             input pex_pkg::data_t exp);
        @(negedge clk);
        dval_i = 1'b1;
        data_i = d;
        mode_i = m;
        exp_data_q.push_back(exp);
        exp_cyc_q.push_back(cyc + 3);
        n_in++;
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(negedge clk);
            dval_i = 1'b0;
        end
    endtask

    // drop valid, then wait for the scoreboard to empty
    task automatic wait_drain(input string test_name);
        int waited;
        waited = 0;
        @(negedge clk);
        dval_i = 1'b0;
        while (exp_data_q.size() != 0 && waited < 20) begin
            @(posedge clk);
            waited++;
        end
        if (exp_data_q.size() != 0) begin
            $display("%s: output never became valid for %0d words within 20 cycles",
                     test_name, exp_data_q.size());
            errors++;
            exp_data_q.delete();
            exp_cyc_q.delete();
        end
    endtask

    task automatic test_reset_idle();
        // monitor expects dval_o low with nothing queued
        idle_cycles(10);
        if (n_out != 0) begin
            $display("reset_idle: output strobe seen with no input word");
            errors++;
        end
    endtask

    task automatic test_seg1();
        send_word(64'h01A5_5A3C_C3F0_0F99, `PEX_MODE_SEG1, 64'h01A5_5A3C_0000_0000);
        send_word(64'h06DE_ADBE_EF12_3456, `PEX_MODE_SEG1, 64'h06DE_ADBE_EF12_3456);
        send_word(64'h1112_3456_789A_BCDE, `PEX_MODE_SEG1, 64'h1112_3456_789A_0000);
        send_word(64'h2AFF_FFFF_FFFF_FFFF, `PEX_MODE_SEG1, 64'h0000_0000_0000_0000);
        wait_drain("seg1");
    endtask

    task automatic test_seg2();
        // upper half is lane 1
        send_word(64'h0611_2233_1144_5566, `PEX_MODE_SEG2, 64'h0611_2233_1144_5500);
        send_word(64'h7F88_9900_01AB_CDEF, `PEX_MODE_SEG2, 64'h0000_0000_01AB_0000);
        send_word(64'h01FF_EEDD_33CC_BBAA, `PEX_MODE_SEG2, 64'h01FF_0000_0000_0000);
        send_word(64'h1100_FFFF_06F0_F0F0, `PEX_MODE_SEG2, 64'h1100_FF00_06F0_F0F0);
        wait_drain("seg2");
    endtask

    task automatic test_seg4();
        // classes rotate through the lanes
        send_word(64'h06AB_11CD_01EF_7734, `PEX_MODE_SEG4, 64'h06AB_11C0_0100_0000);
        send_word(64'hFF12_0134_1156_0678, `PEX_MODE_SEG4, 64'h0000_0100_1150_0678);
        send_word(64'h11FF_22EE_06DD_01CC, `PEX_MODE_SEG4, 64'h11F0_0000_06DD_0100);
        wait_drain("seg4");
    endtask

    function automatic pex_pkg::proto_t pick_proto();
        case ($urandom_range(0, 3))
            0:       return `PEX_PROTO_ICMP;
            1:       return `PEX_PROTO_TCP;
            2:       return `PEX_PROTO_UDP;
            default: return 8'($urandom());
        endcase
    endfunction

    task automatic test_stream();
        int             in0;
        int             out0;
        pex_pkg::data_t d;
        pex_pkg::mode_t m;
        in0 = n_in;
        out0 = n_out;
        for (int i = 0; i < 40; i++) begin
            d = {$urandom(), $urandom()};
            // every SEG4 byte slot covers the SEG1 and SEG2 slots too
            for (int k = 0; k < `PEX_LANES; k++) begin
                d[16*k+8 +: 8] = pick_proto();
            end
            m = 2'($urandom_range(0, 2));
            send_word(d, m, model_word(d, m));
            if ($urandom_range(0, 3) == 0) begin
                idle_cycles($urandom_range(1, 2));
            end
        end
        wait_drain("stream");
        if ((n_out - out0) != (n_in - in0)) begin
            $display("stream: %0d words sent but %0d output strobes seen",
                     n_in - in0, n_out - out0);
            errors++;
        end
    endtask

    // hang guard
    initial begin
        #50000;
        $display("simulation did not finish in time");
        $display("tests failed");
        $finish;
    end

    initial begin
        rst_i = 1'b1;
        dval_i = 1'b0;
        data_i = '0;
        mode_i = `PEX_MODE_SEG1;
        seed_val = $urandom(57);
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst_i = 1'b0;
        test_reset_idle();
        test_seg1();
        test_seg2();
        test_seg4();
        test_stream();
        idle_cycles(2);
        $display("summary: %0d errors, %0d words in, %0d words out", errors, n_in, n_out);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

//--- vlog.f
+incdir+logic
logic/pex_pkg.sv
logic/proto_classify.sv
logic/data_align_delay.sv
logic/seg_mask_deposit.sv
logic/pex_top.sv
dv/pex_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the pex testbench with Verilator

set -u

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=obj_dir/Vpex_tb

verilator --binary --timing --assert -j 0 \
    --top-module pex_tb \
    -f vlog.f \
    -o Vpex_tb
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./${BIN}" > "${LOG}" 2>&1
sim_status=$?
cat "${LOG}"
if [ ${sim_status} -ne 0 ]; then
    echo "simulation exited with status ${sim_status}"
    exit 1
fi

if grep -qx "all tests passed" "${LOG}"; then
    echo "result: PASS"
    exit 0
else
    echo "result: FAIL, see ${LOG}"
    exit 1
fi
